// ==== files.f ====
+incdir+hw
hw/uartLinePkg.sv
hw/uartHostPkg.sv
hw/baudTickGen.sv
hw/uartFifo.sv
hw/uartTrans.sv
hw/uartRecv.sv
hw/uartPeripheral.sv
testbench/uartPeripheral_tb.sv

// ==== hw/baudTickGen.sv ====
//////////////////////////////////////////////////////////////////////
// baud tick generator, one sTick pulse every baudDivisor clocks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_consts.svh"

module baudTickGen (
	input  logic clk,
	input  logic reset,
	output logic sTick    // one clock wide, 16x the bit rate
);

	localparam int divW = $clog2(`baudDivisor + 1);

	logic [divW-1:0] divCnt;    // free-running divider
	logic            wrap;

	assign wrap = (divCnt == divW'(`baudDivisor - 1));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divCnt <= '0;
			sTick  <= 1'b0;
		end
		else
		begin
			if (wrap)
				divCnt <= '0;    // restart period
			else
				divCnt <= divCnt + 1'b1;
			sTick <= wrap;       // registered, so no glitches on the tick
		end
	end

endmodule

// ==== hw/uartFifo.sv ====
//////////////////////////////////////////////////////////////////////
// synchronous FIFO, first-word-fall-through head,
// full / empty flags and occupancy count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_consts.svh"

module uartFifo #(
	parameter int width = `dataBits,
	parameter int depth = `fifoDepth
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         push,
	input  logic [width-1:0]             pushData,
	input  logic                         pop,
	output logic [width-1:0]             head,
	output logic                         full,
	output logic                         empty,
	output logic [$clog2(depth+1)-1:0]   count
);

	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntW = $clog2(depth + 1);

	logic [width-1:0] mem [depth];    // storage, no reset
	logic [ptrW-1:0]  wrPtr;
	logic [ptrW-1:0]  rdPtr;
	logic             doPush;
	logic             doPop;

	// circular pointer step, also for depths that are not a power of two
	function automatic logic [ptrW-1:0] incPtr(input logic [ptrW-1:0] p);
		if (p == ptrW'(depth - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign doPush = push & ~full;     // full drops the new item
	assign doPop  = pop & ~empty;     // pop on empty ignored

	assign full  = (count == cntW'(depth));
	assign empty = (count == '0);
	assign head  = mem[rdPtr];        // head falls through

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= incPtr(wrPtr);
			if (doPop)
				rdPtr <= incPtr(rdPtr);
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // none, or push and pop together
			endcase
		end
	end

endmodule

// ==== hw/uartHostPkg.sv ====
//////////////////////////////////////////////////////////////////////
// processor-side types: UARTwr / UARTrd command and UARTstat word
//////////////////////////////////////////////////////////////////////

package uartHostPkg;

	import uartLinePkg::*;

	// strobes from the instruction decoder
	typedef struct packed {
		logic      wr;       // UARTwr, push wrData to tx FIFO
		logic      rd;       // UARTrd, pop rx FIFO head
		uartData_t wrData;   // byte to send
	} uartCmd_t;

	// status word read by UARTstat
	typedef struct packed {
		logic txFull;
		logic txEmpty;
		logic rxFull;
		logic rxEmpty;
		logic overrun;    // sticky, byte lost on full rx FIFO
		logic frameErr;   // sticky, stop bit sampled low
	} uartStat_t;

endpackage

// ==== hw/uartLinePkg.sv ====
//////////////////////////////////////////////////////////////////////
// serial-line types: character, tick and bit counters,
// FIFO occupancy and the tx / rx FSM state encodings
//////////////////////////////////////////////////////////////////////

`include "uart_consts.svh"

package uartLinePkg;

	typedef logic [`dataBits-1:0] uartData_t;         // one character
	typedef logic [3:0] tickCnt_t;                    // oversample ticks within a bit
	typedef logic [2:0] bitCnt_t;                     // data bit index
	typedef logic [`fifoCntrWidth-1:0] fifoCount_t;   // FIFO occupancy

	// transmitter FSM
	typedef enum logic [1:0] {
		txIdle,       // line high, waiting for FIFO data
		txStartBit,   // driving the low start bit
		txDataBits,   // shifting out, LSB first
		txStopBit     // line high for sbTick ticks
	} txState_t;

	// receiver FSM
	typedef enum logic [1:0] {
		rxIdle,       // waiting for a falling edge
		rxStartBit,   // confirm start at mid-bit
		rxDataBits,   // sample each bit at its middle
		rxStopBit     // check stop bit, then hand off
	} rxState_t;

endpackage

// ==== hw/uartPeripheral.sv ====
//////////////////////////////////////////////////////////////////////
// UART peripheral top: tick generator, tx / rx FIFOs, engines,
// sticky error flags and the UARTstat word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_consts.svh"

module uartPeripheral (
	input  logic                   clk,
	input  logic                   reset,
	input  uartHostPkg::uartCmd_t  cmd,       // UARTwr / UARTrd strobes
	output uartLinePkg::uartData_t rdData,    // rx FIFO head
	output uartHostPkg::uartStat_t stat,
	output logic                   tx,
	input  logic                   rx
);

	import uartLinePkg::*;

	logic      sTick;
	logic      txFull, txEmpty;
	logic      rxFull, rxEmpty;
	logic      txDoneTick;
	logic      rxDoneTick;
	logic      frameErrTick;
	uartData_t txHead;       // next byte for the transmitter
	uartData_t rxByte;       // byte from the receiver
	logic      overrun;
	logic      frameErr;

	baudTickGen tickGen (.clk, .reset, .sTick);

	////////////////////////////////////////////////////////////////////
	// transmit path
	////////////////////////////////////////////////////////////////////
	uartFifo #(.width(`dataBits), .depth(`fifoDepth)) txFifo (
		.clk, .reset,
		.push(cmd.wr), .pushData(cmd.wrData),    // dropped when full
		.pop(txDoneTick), .head(txHead),
		.full(txFull), .empty(txEmpty), .count()
	);

	uartTrans trans (
		.clk, .reset, .sTick,
		.txStart(~txEmpty), .din(txHead),
		.txDoneTick, .tx
	);

	////////////////////////////////////////////////////////////////////
	// receive path
	////////////////////////////////////////////////////////////////////
	uartRecv recv (
		.clk, .reset, .sTick, .rx,
		.rxDoneTick, .frameErrTick, .dout(rxByte)
	);

	uartFifo #(.width(`dataBits), .depth(`fifoDepth)) rxFifo (
		.clk, .reset,
		.push(rxDoneTick), .pushData(rxByte),
		.pop(cmd.rd), .head(rdData),             // rd on empty ignored
		.full(rxFull), .empty(rxEmpty), .count()
	);

	// sticky flags, a new event wins over the clearing rd
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			overrun  <= 1'b0;
			frameErr <= 1'b0;
		end
		else
		begin
			if (rxDoneTick && rxFull)
				overrun <= 1'b1;     // byte lost
			else if (cmd.rd)
				overrun <= 1'b0;
			if (frameErrTick)
				frameErr <= 1'b1;
			else if (cmd.rd)
				frameErr <= 1'b0;
		end
	end

	assign stat.txFull   = txFull;
	assign stat.txEmpty  = txEmpty;
	assign stat.rxFull   = rxFull;
	assign stat.rxEmpty  = rxEmpty;
	assign stat.overrun  = overrun;
	assign stat.frameErr = frameErr;

endmodule

// ==== hw/uartRecv.sv ====
//////////////////////////////////////////////////////////////////////
// UART receiver, 16x oversampling with mid-bit sampling,
// 2-flop rx synchronizer, stop bit check
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_consts.svh"

module uartRecv (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   sTick,
	input  logic                   rx,
	output logic                   rxDoneTick,     // good frame, push dout
	output logic                   frameErrTick,   // stop bit sampled low
	output uartLinePkg::uartData_t dout
);

	import uartLinePkg::*;

	rxState_t  stateReg, stateNext;
	tickCnt_t  sReg, sNext;     // ticks since last sample point
	bitCnt_t   nReg, nNext;     // data bits received
	uartData_t bReg, bNext;     // shift in from the MSB side
	logic      rxMeta;          // first sync stage
	logic      rxSync;          // second sync stage, used by the FSM
	logic      rxPrev;          // for edge detect
	logic      rxFall;

	assign rxFall = rxPrev & ~rxSync;

	// sync and edge detect, all reset to the idle line level
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= rxIdle;
			sReg     <= '0;
			nReg     <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////////////////////////////////////////////////////
	// receive FSM
	////////////////////////////////////////////////////////////////////
	always_comb
	begin
		stateNext    = stateReg;
		sNext        = sReg;
		nNext        = nReg;
		bNext        = bReg;
		rxDoneTick   = 1'b0;
		frameErrTick = 1'b0;

		case (stateReg)
			rxIdle:
			begin
				if (rxFall)
				begin
					sNext     = '0;
					stateNext = rxStartBit;
				end
			end
			rxStartBit:
			begin
				if (sTick)
				begin
					if (sReg == tickCnt_t'(`overSample / 2 - 1))    // middle of start bit
					begin
						sNext = '0;
						nNext = '0;
						if (rxSync)
							stateNext = rxIdle;       // glitch, line back high
						else
							stateNext = rxDataBits;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			rxDataBits:
			begin
				if (sTick)
				begin
					if (sReg == tickCnt_t'(`overSample - 1))
					begin
						sNext = '0;
						bNext = {rxSync, bReg[`dataBits-1:1]};    // LSB arrives first
						if (nReg == bitCnt_t'(`dataBits - 1))
							stateNext = rxStopBit;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			rxStopBit:
			begin
				if (sTick)
				begin
					if (sReg == tickCnt_t'(`sbTick - 1))    // middle of stop bit
					begin
						rxDoneTick   = rxSync;
						frameErrTick = ~rxSync;    // byte is dropped
						stateNext    = rxIdle;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = rxIdle;
		endcase
	end

	assign dout = bReg;

endmodule

// ==== hw/uartTrans.sv ====
//////////////////////////////////////////////////////////////////////
// UART transmitter, 4-state FSM: idle, start, data, stop
// one start bit, dataBits LSB first, one stop bit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_consts.svh"

module uartTrans (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   sTick,
	input  logic                   txStart,      // tx FIFO not empty
	input  uartLinePkg::uartData_t din,          // tx FIFO head
	output logic                   txDoneTick,   // pops the tx FIFO
	output logic                   tx
);

	import uartLinePkg::*;

	txState_t  stateReg, stateNext;
	tickCnt_t  sReg, sNext;      // ticks within the current bit
	bitCnt_t   nReg, nNext;      // data bits sent
	uartData_t bReg, bNext;      // shift register, LSB on the line
	logic      txReg, txNext;    // line level, registered

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= txIdle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;    // line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			txReg    <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////////////////////////////////////////////////////
	// next state; txNext changes together with the state so every
	// bit holds for its full tick count
	////////////////////////////////////////////////////////////////////
	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		txNext     = txReg;
		txDoneTick = 1'b0;

		case (stateReg)
			txIdle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txDoneTick = 1'b1;    // accept, FIFO head moves on this edge
					bNext      = din;     // so latch it now
					txNext     = 1'b0;    // start bit on the next clock
					sNext      = '0;
					stateNext  = txStartBit;
				end
			end
			txStartBit:
			begin
				if (sTick)
				begin
					if (sReg == tickCnt_t'(`overSample - 1))
					begin
						sNext     = '0;
						nNext     = '0;
						txNext    = bReg[0];    // first data bit
						stateNext = txDataBits;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			txDataBits:
			begin
				if (sTick)
				begin
					if (sReg == tickCnt_t'(`overSample - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == bitCnt_t'(`dataBits - 1))
						begin
							txNext    = 1'b1;      // stop bit
							stateNext = txStopBit;
						end
						else
						begin
							txNext = bReg[1];    // next bit after the shift
							nNext  = nReg + 1'b1;
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			txStopBit:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == tickCnt_t'(`sbTick - 1))
						stateNext = txIdle;    // back to back frames start from here
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = txIdle;
		endcase
	end

	assign tx = txReg;

endmodule

// ==== hw/uart_consts.svh ====
//////////////////////////////////////////////////////////////////////
// UART peripheral constants: character format, oversampling,
// baud divisor and FIFO sizing
//////////////////////////////////////////////////////////////////////

`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// character format
`define dataBits       8    // bits per character
`define sbTick         16   // ticks in the stop bit, one stop bit only

// line timing
`define overSample     16   // ticks per data bit
`define baudDivisor    4    // clocks per tick, small so simulation stays short

// FIFOs, tx and rx use the same sizing
`define fifoDepth      16
`define fifoCntrWidth  5    // holds 0..16

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the UART peripheral testbench with Verilator, run it, check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f files.f \
	--top-module uartPeripheral_tb \
	--Mdir obj_dir \
	-o simv

./obj_dir/simv | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
	echo "simulation run passed, see sim.log"
else
	echo "simulation run failed, see sim.log"
	exit 1
fi

// ==== testbench/uartPeripheral_tb.sv ====
//////////////////////////////////////////////////////////////////////
// UART peripheral testbench: host stimulus, serial-line driver,
// reference model, rdData compare process and watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "uart_consts.svh"

module uartPeripheral_tb;

	import uartLinePkg::*;
	import uartHostPkg::*;

	localparam int bitClocks      = `overSample * `baudDivisor;     // 64 clocks per bit
	localparam int frameClocks    = (`dataBits + 2) * bitClocks;    // start, data, stop
	localparam int watchdogClocks = 40 * frameClocks;

	logic      clk = 1'b0;
	logic      reset;
	uartCmd_t  cmd;
	uartData_t rdData;
	uartStat_t stat;
	logic      tx;
	logic      rx;
	logic      drvLine;     // bit-banged line from the driver task
	logic      loopSel;     // 1 = tx looped back to rx

	integer    seed;
	int        errors = 0;
	uartData_t expQ[$];     // bytes the host should read, in order
	uartData_t expByte;
	int        txOcc;
	int        rxOcc;
	logic      ovrExp;
	uartData_t b;
	int        n;

	assign rx = loopSel ? tx : drvLine;    // line mux

	always #20 clk = ~clk;

	uartPeripheral u_dut (.clk, .reset, .cmd, .rdData, .stat, .tx, .rx);

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// full FIFO drops the new item
	function automatic bit fifoAccepts(input int occupancy);
		return occupancy < `fifoDepth;
	endfunction

	// status word from model occupancies and sticky flags
	function automatic uartStat_t expectStat(input int txCount, input int rxCount,
		input logic ovr, input logic ferr);
		uartStat_t s;
		s.txFull   = (txCount == `fifoDepth);
		s.txEmpty  = (txCount == 0);
		s.rxFull   = (rxCount == `fifoDepth);
		s.rxEmpty  = (rxCount == 0);
		s.overrun  = ovr;
		s.frameErr = ferr;
		return s;
	endfunction

	function automatic uartData_t randByte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// host side tasks
	//////////////////////////////////////////////////////////////////////

	// wr on consecutive cycles, transmitter idle at the start
	task automatic writeBurst(input int count, output int occOut);
		int        occ;
		bit        txIdle;
		bit        popNow;
		uartData_t d;
		occ    = 0;
		txIdle = 1'b1;
		for (int i = 0; i < count; i++)
		begin
			d = randByte();
			@(posedge clk);
			cmd.wr     <= 1'b1;
			cmd.wrData <= d;
			popNow = txIdle && (occ > 0);    // head taken by the idle transmitter
			if (fifoAccepts(occ))
			begin
				occ++;
				expQ.push_back(d);
			end
			if (popNow)
			begin
				occ--;
				txIdle = 1'b0;
			end
		end
		@(posedge clk);
		cmd.wr <= 1'b0;
		occOut = occ;
	endtask

	task automatic readByte();
		@(posedge clk);
		cmd.rd <= 1'b1;
		@(posedge clk);
		cmd.rd <= 1'b0;
	endtask

	task automatic waitRxData(input int limit);
		int k;
		k = 0;
		@(negedge clk);
		while (stat.rxEmpty && k < limit)
		begin
			@(negedge clk);
			k++;
		end
		if (stat.rxEmpty)
		begin
			errors++;
			$display("no received byte showed up within %0d clocks at %0t", limit, $time);
		end
	endtask

	task automatic checkStat(input uartStat_t exp, input string what);
		@(negedge clk);    // outputs settled
		assert (stat == exp)
		else
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s, stat %b expected %b", $time, what, stat, exp);
		end
	endtask

	// one frame on drvLine, 64 clocks per bit, LSB first
	task automatic sendFrame(input uartData_t d, input logic stopLevel);
		logic [`dataBits+1:0] bits;
		bits = {stopLevel, d, 1'b0};
		for (int i = 0; i < `dataBits + 2; i++)
		begin
			@(posedge clk);
			drvLine <= bits[i];
			repeat (bitClocks - 1) @(posedge clk);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare process, every accepted rd against the queue head
	//////////////////////////////////////////////////////////////////////
	always @(posedge clk)
	begin
		if (!reset && cmd.rd && !stat.rxEmpty)
		begin
			if (expQ.size() == 0)
			begin
				errors++;
				$display("received byte %h at %0t that no test expected", rdData, $time);
			end
			else
			begin
				expByte = expQ.pop_front();
				assert (rdData == expByte)
				else
				begin
					errors++;
					$display("CHECK FAILED at %0t: rdData %h expected %h",
						$time, rdData, expByte);
				end
			end
		end
	end

	// watchdog, 40 frame times covers all tests
	initial
	begin
		repeat (watchdogClocks) @(posedge clk);
		$display("timeout after %0d clocks, errors so far: %0d", watchdogClocks, errors);
		$display("*** FAILED ***");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		seed    = 32'h2befadf6;
		loopSel = 1'b0;
		reset   <= 1'b1;
		cmd     <= '0;
		drvLine <= 1'b1;
		repeat (5) @(posedge clk);
		reset   <= 1'b0;
		loopSel = 1'b1;    // both lines idle high here

		// after reset: line idle, FIFOs empty, no flags
		repeat (8)
		begin
			@(negedge clk);
			assert (tx == 1'b1)
			else
			begin
				errors++;
				$display("CHECK FAILED at %0t: tx low after reset", $time);
			end
		end
		checkStat(expectStat(0, 0, 1'b0, 1'b0), "after reset");

		// single byte in loopback
		writeBurst(1, txOcc);
		waitRxData(2 * frameClocks);
		checkStat(expectStat(0, 1, 1'b0, 1'b0), "single byte arrived");
		readByte();
		checkStat(expectStat(0, 0, 1'b0, 1'b0), "single byte read");
		repeat (bitClocks) @(posedge clk);    // rest of the stop bit

		// burst of 18, first one popped early, last one dropped
		writeBurst(18, txOcc);
		checkStat(expectStat(txOcc, 0, 1'b0, 1'b0), "burst written");
		n = expQ.size();
		repeat (n)
		begin
			waitRxData(2 * frameClocks);
			readByte();
		end
		checkStat(expectStat(0, 0, 1'b0, 1'b0), "burst drained");

		// 17 frames from the driver, no reads
		loopSel = 1'b0;
		rxOcc   = 0;
		ovrExp  = 1'b0;
		repeat (17)
		begin
			b = randByte();
			if (fifoAccepts(rxOcc))
			begin
				rxOcc++;
				expQ.push_back(b);
			end
			else
				ovrExp = 1'b1;    // lost on full rx FIFO
			sendFrame(b, 1'b1);
		end
		checkStat(expectStat(0, rxOcc, ovrExp, 1'b0), "rx overrun");
		readByte();
		checkStat(expectStat(0, rxOcc - 1, 1'b0, 1'b0), "first rd clears overrun");
		repeat (rxOcc - 1) readByte();
		checkStat(expectStat(0, 0, 1'b0, 1'b0), "rx FIFO drained");

		// low stop bit, then a good frame
		sendFrame(randByte(), 1'b0);
		@(posedge clk);
		drvLine <= 1'b1;
		repeat (bitClocks) @(posedge clk);
		checkStat(expectStat(0, 0, 1'b0, 1'b1), "framing error");
		b = randByte();
		expQ.push_back(b);
		sendFrame(b, 1'b1);
		waitRxData(2 * frameClocks);
		checkStat(expectStat(0, 1, 1'b0, 1'b1), "good frame after framing error");
		readByte();
		checkStat(expectStat(0, 0, 1'b0, 1'b0), "rd clears frameErr");

		assert (expQ.size() == 0)
		else
		begin
			errors++;
			$display("%0d expected bytes never arrived", expQ.size());
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
